// File: uart_line_pkg.sv
/*
 * Serial side definitions of the UART
 * Byte, FIFO and counter widths, frame configuration,
 * received frame record and the TX/RX state encodings
 */

package uart_line_pkg;

	typedef logic [7:0] data_t;

	localparam int OVERSAMPLE = 16;
	localparam int FIFO_DEPTH = 16;

	typedef logic [3:0] fifo_ptr_t;
	typedef logic [4:0] fifo_count_t;
	typedef logic [3:0] sample_cnt_t;
	typedef logic [2:0] bit_cnt_t;

	// Data bits per frame are 5 + word_len
	typedef struct packed {
		logic [1:0] word_len;
		logic       two_stop;
		logic       parity_en;
		logic       even_parity;
	} lc_cfg_t;

	typedef struct packed {
		data_t data;
		logic  parity_err;
		logic  frame_err;
	} rx_frame_t;

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;
	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage

// File: uart_reg_pkg.sv
/*
 * Bus side definitions of the UART
 * Register map, LC/MC/LS bit positions and the Wishbone request
 */

package uart_reg_pkg;

	typedef logic [2:0]  reg_addr_t;
	typedef logic [15:0] divisor_t;

	// ******************************
	// Register map
	// ******************************
	localparam reg_addr_t REG_RB_TR = 3'd0;
	localparam reg_addr_t REG_DLM   = 3'd1;
	localparam reg_addr_t REG_LC    = 3'd3;
	localparam reg_addr_t REG_MC    = 3'd4;
	localparam reg_addr_t REG_LS    = 3'd5;

	// Line control bits, word length in bits 1:0
	localparam int LC_WLEN = 0;
	localparam int LC_STOP = 2;
	localparam int LC_PEN  = 3;
	localparam int LC_EPS  = 4;
	localparam int LC_DLAB = 7;

	localparam logic [7:0] LC_RESET = 8'h03;

	localparam int MC_LOOP = 4;

	// Line status
	localparam int LS_DR   = 0;
	localparam int LS_OE   = 1;
	localparam int LS_PE   = 2;
	localparam int LS_FE   = 3;
	localparam int LS_THRE = 5;
	localparam int LS_TEMT = 6;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		reg_addr_t            adr;
		uart_line_pkg::data_t dat_w;
	} wb_req_t;

endpackage

// File: uart_fifo.sv
/*
 * Byte FIFO with first-word-fall-through output
 * Circular buffer, read/write pointers and fill counter
 */

module uart_fifo (
	input  logic                 rvx_port_07,
	input  logic                 rvx_port_12,
	input  logic                 push,
	input  uart_line_pkg::data_t push_data,
	input  logic                 pop,
	output uart_line_pkg::data_t pop_data,
	output logic                 full,
	output logic                 empty
);

	uart_line_pkg::data_t       mem [uart_line_pkg::FIFO_DEPTH];
	uart_line_pkg::fifo_ptr_t   wr_ptr;
	uart_line_pkg::fifo_ptr_t   rd_ptr;
	uart_line_pkg::fifo_count_t count;

	always_ff @(posedge rvx_port_07)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];
	assign full     = (count == uart_line_pkg::fifo_count_t'(uart_line_pkg::FIFO_DEPTH));
	assign empty    = (count == '0);

endmodule

// File: uart_baud_gen.sv
/*
 * Baud tick generator
 * Down-counter giving one tick every divisor clocks
 */

module uart_baud_gen (
	input  logic                    rvx_port_07,
	input  logic                    rvx_port_12,
	input  uart_reg_pkg::divisor_t  divisor,
	input  logic                    divisor_load,
	output logic                    tick
);

	uart_reg_pkg::divisor_t count;

	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			count <= '0;
			tick  <= 1'b0;
		end
		else if (divisor_load)
		begin
			count <= divisor - 1'b1;
			tick  <= 1'b0;
		end
		else if (divisor == '0)
		begin
			// Stopped
			count <= '0;
			tick  <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= divisor - 1'b1;
			tick  <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

// File: uart_tx.sv
/*
 * UART transmitter
 * Pops the TX FIFO and shifts out start, data, parity and stop bits
 */

module uart_tx (
	input  logic                   rvx_port_07,
	input  logic                   rvx_port_12,
	input  logic                   tick,
	input  uart_line_pkg::lc_cfg_t line_cfg,
	input  logic                   fifo_empty,
	input  uart_line_pkg::data_t   fifo_data,
	output logic                   fifo_pop,
	output logic                   tx_busy,
	output logic                   serial_out
);

	uart_line_pkg::tx_state_e   state;
	uart_line_pkg::sample_cnt_t sample_cnt;
	uart_line_pkg::bit_cnt_t    bit_cnt;
	uart_line_pkg::bit_cnt_t    last_bit;
	uart_line_pkg::data_t       shift;
	uart_line_pkg::data_t       load_data;
	logic                       parity_bit;
	logic                       bit_end;

	// Unused upper bits are dropped before the parity is taken
	assign load_data = fifo_data & (8'hff >> (2'd3 - line_cfg.word_len));
	assign last_bit  = 3'd4 + {1'b0, line_cfg.word_len};
	assign bit_end   = tick && (sample_cnt == uart_line_pkg::sample_cnt_t'(uart_line_pkg::OVERSAMPLE - 1));

	assign fifo_pop = (state == uart_line_pkg::TX_IDLE) && tick && !fifo_empty;
	assign tx_busy  = (state != uart_line_pkg::TX_IDLE);

	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			state      <= uart_line_pkg::TX_IDLE;
			sample_cnt <= '0;
			bit_cnt    <= '0;
			shift      <= '0;
			parity_bit <= 1'b0;
			serial_out <= 1'b1;
		end
		else if (state == uart_line_pkg::TX_IDLE)
		begin
			if (fifo_pop)
			begin
				shift      <= load_data;
				parity_bit <= ^load_data ^ ~line_cfg.even_parity;
				sample_cnt <= '0;
				bit_cnt    <= '0;
				serial_out <= 1'b0;
				state      <= uart_line_pkg::TX_START;
			end
		end
		else if (tick)
		begin
			sample_cnt <= sample_cnt + 1'b1;
			if (bit_end)
			begin
				case (state)
					uart_line_pkg::TX_START:
					begin
						serial_out <= shift[0];
						state      <= uart_line_pkg::TX_DATA;
					end
					uart_line_pkg::TX_DATA:
					begin
						if (bit_cnt == last_bit)
						begin
							bit_cnt    <= '0;
							serial_out <= line_cfg.parity_en ? parity_bit : 1'b1;
							state      <= line_cfg.parity_en ? uart_line_pkg::TX_PARITY
							                                 : uart_line_pkg::TX_STOP;
						end
						else
						begin
							bit_cnt    <= bit_cnt + 1'b1;
							shift      <= shift >> 1;
							serial_out <= shift[1];
						end
					end
					uart_line_pkg::TX_PARITY:
					begin
						serial_out <= 1'b1;
						state      <= uart_line_pkg::TX_STOP;
					end
					default:
					begin
						// Second stop bit reuses the bit counter
						if (line_cfg.two_stop && (bit_cnt == '0))
							bit_cnt <= 3'd1;
						else
							state <= uart_line_pkg::TX_IDLE;
					end
				endcase
			end
		end
	end

endmodule

// File: uart_rx.sv
/*
 * UART receiver
 * Input synchronizer, start edge detection and mid-bit sampling
 * of data, parity and the first stop bit
 */

module uart_rx (
	input  logic                     rvx_port_07,
	input  logic                     rvx_port_12,
	input  logic                     tick,
	input  uart_line_pkg::lc_cfg_t   line_cfg,
	input  logic                     serial_in,
	output uart_line_pkg::rx_frame_t frame,
	output logic                     frame_valid
);

	uart_line_pkg::rx_state_e   state;
	uart_line_pkg::sample_cnt_t sample_cnt;
	uart_line_pkg::bit_cnt_t    bit_cnt;
	uart_line_pkg::bit_cnt_t    last_bit;
	logic                       sync_0;
	logic                       sync_1;
	logic                       line_prev;
	logic                       start_edge;
	logic                       half_bit;
	logic                       full_bit;

	// ******************************
	// Synchronizer
	// ******************************
	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			sync_0    <= 1'b1;
			sync_1    <= 1'b1;
			line_prev <= 1'b1;
		end
		else
		begin
			sync_0    <= serial_in;
			sync_1    <= sync_0;
			line_prev <= sync_1;
		end
	end

	assign start_edge = line_prev && !sync_1;
	assign last_bit   = 3'd4 + {1'b0, line_cfg.word_len};
	assign half_bit   = tick && (sample_cnt ==
		uart_line_pkg::sample_cnt_t'(uart_line_pkg::OVERSAMPLE / 2 - 1));
	assign full_bit   = tick && (sample_cnt ==
		uart_line_pkg::sample_cnt_t'(uart_line_pkg::OVERSAMPLE - 1));

	// ******************************
	// Frame FSM
	// ******************************
	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			state       <= uart_line_pkg::RX_IDLE;
			sample_cnt  <= '0;
			bit_cnt     <= '0;
			frame       <= '0;
			frame_valid <= 1'b0;
		end
		else
		begin
			frame_valid <= 1'b0;
			if (tick)
				sample_cnt <= sample_cnt + 1'b1;
			case (state)
				uart_line_pkg::RX_IDLE:
				begin
					if (start_edge)
					begin
						sample_cnt       <= '0;
						bit_cnt          <= '0;
						frame.data       <= '0;
						frame.parity_err <= 1'b0;
						state            <= uart_line_pkg::RX_START;
					end
				end
				uart_line_pkg::RX_START:
				begin
					// A high line in the middle of the start bit was a glitch
					if (half_bit)
					begin
						sample_cnt <= '0;
						state      <= sync_1 ? uart_line_pkg::RX_IDLE : uart_line_pkg::RX_DATA;
					end
				end
				uart_line_pkg::RX_DATA:
				begin
					if (full_bit)
					begin
						frame.data[bit_cnt] <= sync_1;
						bit_cnt             <= bit_cnt + 1'b1;
						if (bit_cnt == last_bit)
							state <= line_cfg.parity_en ? uart_line_pkg::RX_PARITY
							                            : uart_line_pkg::RX_STOP;
					end
				end
				uart_line_pkg::RX_PARITY:
				begin
					if (full_bit)
					begin
						frame.parity_err <= ^frame.data ^ sync_1 ^ ~line_cfg.even_parity;
						state            <= uart_line_pkg::RX_STOP;
					end
				end
				default:
				begin
					if (full_bit)
					begin
						frame.frame_err <= !sync_1;
						frame_valid     <= 1'b1;
						state           <= uart_line_pkg::RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: uart_bus_regs.sv
/*
 * Wishbone register block of the UART
 * LC, MC and divisor storage, read mux, line status flags
 * and the push/pop control of both FIFOs
 */

module uart_bus_regs (
	input  logic                     rvx_port_07,
	input  logic                     rvx_port_12,
	input  uart_reg_pkg::wb_req_t    wb_req,
	input  logic                     tx_full,
	input  logic                     tx_empty,
	input  logic                     tx_busy,
	input  uart_line_pkg::rx_frame_t rx_frame,
	input  logic                     frame_valid,
	input  uart_line_pkg::data_t     rx_data,
	input  logic                     rx_full,
	input  logic                     rx_empty,
	output uart_line_pkg::data_t     wb_dat_r,
	output logic                     wb_ack,
	output logic                     tx_push,
	output uart_line_pkg::data_t     tx_data,
	output logic                     rx_push,
	output logic                     rx_pop,
	output uart_line_pkg::lc_cfg_t   line_cfg,
	output uart_reg_pkg::divisor_t   divisor,
	output logic                     divisor_load,
	output logic                     loopback
);

	uart_line_pkg::data_t lc;
	uart_line_pkg::data_t ls;
	uart_line_pkg::data_t mc_val;
	uart_line_pkg::data_t rd_mux;
	logic                 dlab;
	logic                 access;
	logic                 wr;
	logic                 rd;
	logic                 dl_wr;
	logic                 ls_rd;
	logic                 oe_flag;
	logic                 pe_flag;
	logic                 fe_flag;

	// Request accepted in the cycle that raises ack
	assign access = wb_req.cyc && wb_req.stb && !wb_ack;
	assign wr     = access && wb_req.we;
	assign rd     = access && !wb_req.we;
	assign dlab   = lc[uart_reg_pkg::LC_DLAB];
	assign dl_wr  = wr && dlab &&
		((wb_req.adr == uart_reg_pkg::REG_RB_TR) || (wb_req.adr == uart_reg_pkg::REG_DLM));
	assign ls_rd  = rd && (wb_req.adr == uart_reg_pkg::REG_LS);

	// ******************************
	// FIFO control
	// ******************************
	assign tx_push = wr && !dlab && (wb_req.adr == uart_reg_pkg::REG_RB_TR) && !tx_full;
	assign tx_data = wb_req.dat_w;
	assign rx_push = frame_valid && !rx_full;
	assign rx_pop  = rd && !dlab && (wb_req.adr == uart_reg_pkg::REG_RB_TR) && !rx_empty;

	assign line_cfg.word_len    = lc[uart_reg_pkg::LC_WLEN +: 2];
	assign line_cfg.two_stop    = lc[uart_reg_pkg::LC_STOP];
	assign line_cfg.parity_en   = lc[uart_reg_pkg::LC_PEN];
	assign line_cfg.even_parity = lc[uart_reg_pkg::LC_EPS];

	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			wb_ack       <= 1'b0;
			lc           <= uart_reg_pkg::LC_RESET;
			loopback     <= 1'b0;
			divisor      <= '0;
			divisor_load <= 1'b0;
		end
		else
		begin
			wb_ack       <= access;
			divisor_load <= dl_wr;
			if (wr && (wb_req.adr == uart_reg_pkg::REG_LC))
				lc <= wb_req.dat_w;
			if (wr && (wb_req.adr == uart_reg_pkg::REG_MC))
				loopback <= wb_req.dat_w[uart_reg_pkg::MC_LOOP];
			if (dl_wr && (wb_req.adr == uart_reg_pkg::REG_RB_TR))
				divisor[7:0] <= wb_req.dat_w;
			if (dl_wr && (wb_req.adr == uart_reg_pkg::REG_DLM))
				divisor[15:8] <= wb_req.dat_w;
		end
	end

	// ******************************
	// Line status
	// ******************************
	// A new error in the clearing cycle survives the LS read
	always_ff @(posedge rvx_port_07 or posedge rvx_port_12)
	begin
		if (rvx_port_12)
		begin
			oe_flag <= 1'b0;
			pe_flag <= 1'b0;
			fe_flag <= 1'b0;
		end
		else
		begin
			oe_flag <= (oe_flag && !ls_rd) || (frame_valid && rx_full);
			pe_flag <= (pe_flag && !ls_rd) || (frame_valid && rx_frame.parity_err);
			fe_flag <= (fe_flag && !ls_rd) || (frame_valid && rx_frame.frame_err);
		end
	end

	always_comb
	begin
		ls                           = '0;
		ls[uart_reg_pkg::LS_DR]      = !rx_empty;
		ls[uart_reg_pkg::LS_OE]      = oe_flag;
		ls[uart_reg_pkg::LS_PE]      = pe_flag;
		ls[uart_reg_pkg::LS_FE]      = fe_flag;
		ls[uart_reg_pkg::LS_THRE]    = tx_empty;
		ls[uart_reg_pkg::LS_TEMT]    = tx_empty && !tx_busy;
		mc_val                       = '0;
		mc_val[uart_reg_pkg::MC_LOOP] = loopback;
	end

	always_comb
	begin
		case (wb_req.adr)
			uart_reg_pkg::REG_RB_TR: rd_mux = dlab ? divisor[7:0] : rx_data;
			uart_reg_pkg::REG_DLM:   rd_mux = dlab ? divisor[15:8] : '0;
			uart_reg_pkg::REG_LC:    rd_mux = lc;
			uart_reg_pkg::REG_MC:    rd_mux = mc_val;
			uart_reg_pkg::REG_LS:    rd_mux = ls;
			default:                 rd_mux = '0;
		endcase
	end

	// Read data is held for the ack cycle
	always_ff @(posedge rvx_port_07)
	begin
		if (rd)
			wb_dat_r <= rd_mux;
	end

endmodule

// File: uart_core.sv
/*
 * UART top level
 * Register block, baud generator, TX/RX FIFOs, serializer,
 * deserializer and loopback selection
 */

module uart_core (
	input  logic                  rvx_port_07,
	input  logic                  rvx_port_12,
	input  uart_reg_pkg::wb_req_t wb_req,
	input  logic                  serial_in,
	output uart_line_pkg::data_t  wb_dat_r,
	output logic                  wb_ack,
	output logic                  serial_out
);

	logic                     tx_push;
	logic                     tx_pop;
	logic                     tx_full;
	logic                     tx_empty;
	logic                     tx_busy;
	logic                     rx_push;
	logic                     rx_pop;
	logic                     rx_full;
	logic                     rx_empty;
	logic                     frame_valid;
	logic                     divisor_load;
	logic                     loopback;
	logic                     tick;
	logic                     tx_line;
	logic                     rx_line;
	uart_line_pkg::data_t     tx_data;
	uart_line_pkg::data_t     tx_fifo_data;
	uart_line_pkg::data_t     rx_data;
	uart_line_pkg::rx_frame_t rx_frame;
	uart_line_pkg::lc_cfg_t   line_cfg;
	uart_reg_pkg::divisor_t   divisor;

	// Loopback keeps the pin idle and feeds the receiver from the transmitter
	assign rx_line    = loopback ? tx_line : serial_in;
	assign serial_out = loopback ? 1'b1 : tx_line;

	uart_bus_regs i_bus_regs (
		.rvx_port_07  (rvx_port_07),
		.rvx_port_12  (rvx_port_12),
		.wb_req       (wb_req),
		.tx_full      (tx_full),
		.tx_empty     (tx_empty),
		.tx_busy      (tx_busy),
		.rx_frame     (rx_frame),
		.frame_valid  (frame_valid),
		.rx_data      (rx_data),
		.rx_full      (rx_full),
		.rx_empty     (rx_empty),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.tx_push      (tx_push),
		.tx_data      (tx_data),
		.rx_push      (rx_push),
		.rx_pop       (rx_pop),
		.line_cfg     (line_cfg),
		.divisor      (divisor),
		.divisor_load (divisor_load),
		.loopback     (loopback)
	);

	uart_baud_gen i_baud_gen (
		.rvx_port_07  (rvx_port_07),
		.rvx_port_12  (rvx_port_12),
		.divisor      (divisor),
		.divisor_load (divisor_load),
		.tick         (tick)
	);

	uart_fifo i_tx_fifo (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_12 (rvx_port_12),
		.push        (tx_push),
		.push_data   (tx_data),
		.pop         (tx_pop),
		.pop_data    (tx_fifo_data),
		.full        (tx_full),
		.empty       (tx_empty)
	);

	uart_tx i_tx (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_12 (rvx_port_12),
		.tick        (tick),
		.line_cfg    (line_cfg),
		.fifo_empty  (tx_empty),
		.fifo_data   (tx_fifo_data),
		.fifo_pop    (tx_pop),
		.tx_busy     (tx_busy),
		.serial_out  (tx_line)
	);

	uart_rx i_rx (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_12 (rvx_port_12),
		.tick        (tick),
		.line_cfg    (line_cfg),
		.serial_in   (rx_line),
		.frame       (rx_frame),
		.frame_valid (frame_valid)
	);

	uart_fifo i_rx_fifo (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_12 (rvx_port_12),
		.push        (rx_push),
		.push_data   (rx_frame.data),
		.pop         (rx_pop),
		.pop_data    (rx_data),
		.full        (rx_full),
		.empty       (rx_empty)
	);

endmodule

// File: tb_uart.sv
/*
 * Testbench of the UART core
 * Clock and reset, LFSR stimulus, Wishbone and serial line tasks,
 * reference frame function, serial_out monitor and test sequence
 */

module tb_uart;

	typedef struct packed {
		logic                 parity;
		uart_line_pkg::data_t data;
	} ref_t;

	typedef struct packed {
		uart_line_pkg::lc_cfg_t cfg;
		uart_line_pkg::data_t   data;
	} tx_item_t;

	localparam int ACK_TIMEOUT = 16;
	localparam int LS_TIMEOUT  = 2000;
	localparam int MON_TIMEOUT = 20000;

	logic                  clk;
	logic                  rst;
	uart_reg_pkg::wb_req_t wb_req;
	logic                  serial_in;
	uart_line_pkg::data_t  wb_dat_r;
	logic                  wb_ack;
	logic                  serial_out;

	logic [31:0] lfsr;
	int          value_errs;
	int          other_errs;
	int          bit_clks;
	logic        loop_mode;
	logic        mon_prev = 1'b1;
	logic        mon_busy = 1'b0;
	tx_item_t    mon_q[$];

	uart_core i_dut (
		.rvx_port_07 (clk),
		.rvx_port_12 (rst),
		.wb_req      (wb_req),
		.serial_in   (serial_in),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.serial_out  (serial_out)
	);

	always #5 clk = ~clk;

	// ******************************
	// Stimulus and reference
	// ******************************
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// Taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output uart_line_pkg::data_t b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	function automatic ref_t ref_frame(input uart_line_pkg::data_t d,
		input uart_line_pkg::lc_cfg_t cfg);
		ref_t r;
		int   nbits;
		nbits  = 5 + cfg.word_len;
		r.data = '0;
		for (int i = 0; i < nbits; i++)
			r.data[i] = d[i];
		// Even parity keeps the count of ones even including the parity bit
		r.parity = cfg.even_parity ? ^r.data : ~^r.data;
		return r;
	endfunction

	function automatic uart_line_pkg::data_t lc_byte(input uart_line_pkg::lc_cfg_t cfg);
		uart_line_pkg::data_t v;
		v                               = '0;
		v[uart_reg_pkg::LC_WLEN +: 2]   = cfg.word_len;
		v[uart_reg_pkg::LC_STOP]        = cfg.two_stop;
		v[uart_reg_pkg::LC_PEN]         = cfg.parity_en;
		v[uart_reg_pkg::LC_EPS]         = cfg.even_parity;
		return v;
	endfunction

	// ******************************
	// Checks and run control
	// ******************************
	task automatic check_byte(input string name, input uart_line_pkg::data_t expected,
		input uart_line_pkg::data_t actual);
		if (actual !== expected)
		begin
			value_errs++;
			$display("ERR %s expected %02h actual %02h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			value_errs++;
			$display("ERR %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic end_run();
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		other_errs++;
		$display("Timeout while waiting for %s", what);
		end_run();
	endtask

	// ******************************
	// Bus and line tasks
	// ******************************
	task automatic wb_cycle(input logic we, input uart_reg_pkg::reg_addr_t adr,
		input uart_line_pkg::data_t dat_w, output uart_line_pkg::data_t dat_r);
		uart_reg_pkg::wb_req_t req;
		int                    waited;
		waited    = 0;
		req.cyc   = 1'b1;
		req.stb   = 1'b1;
		req.we    = we;
		req.adr   = adr;
		req.dat_w = dat_w;
		@(posedge clk);
		wb_req <= req;
		@(negedge clk);
		while (!wb_ack)
		begin
			if (waited == ACK_TIMEOUT)
				timeout_abort("Wishbone ack");
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		dat_r = wb_dat_r;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic wb_write(input uart_reg_pkg::reg_addr_t adr, input uart_line_pkg::data_t d);
		uart_line_pkg::data_t unused;
		wb_cycle(1'b1, adr, d, unused);
	endtask

	task automatic wb_read(input uart_reg_pkg::reg_addr_t adr, output uart_line_pkg::data_t d);
		wb_cycle(1'b0, adr, 8'h00, d);
	endtask

	// Polls LS and hands back the value that showed the bit
	task automatic wait_ls(input int bit_pos, input logic value, input string what,
		output uart_line_pkg::data_t ls);
		int tries;
		tries = 0;
		wb_read(uart_reg_pkg::REG_LS, ls);
		while (ls[bit_pos] !== value)
		begin
			if (tries == LS_TIMEOUT)
				timeout_abort(what);
			else
			begin
				tries++;
				wb_read(uart_reg_pkg::REG_LS, ls);
			end
		end
	endtask

	task automatic wait_monitor_idle();
		int waited;
		waited = 0;
		while (mon_q.size() != 0 || mon_busy)
		begin
			if (waited == MON_TIMEOUT)
				timeout_abort("frames on serial_out");
			else
			begin
				waited++;
				@(posedge clk);
			end
		end
	endtask

	task automatic set_line(input uart_line_pkg::lc_cfg_t cfg);
		wb_write(uart_reg_pkg::REG_LC, lc_byte(cfg));
	endtask

	task automatic set_divisor(input uart_reg_pkg::divisor_t div,
		input uart_line_pkg::lc_cfg_t cfg);
		wb_write(uart_reg_pkg::REG_LC, lc_byte(cfg) | (8'h01 << uart_reg_pkg::LC_DLAB));
		wb_write(uart_reg_pkg::REG_RB_TR, div[7:0]);
		wb_write(uart_reg_pkg::REG_DLM, div[15:8]);
		set_line(cfg);
		bit_clks = uart_line_pkg::OVERSAMPLE * div;
	endtask

	task automatic drive_bit(input logic b);
		@(posedge clk);
		serial_in <= b;
		repeat (bit_clks - 1) @(posedge clk);
	endtask

	task automatic send_frame(input uart_line_pkg::data_t d, input uart_line_pkg::lc_cfg_t cfg,
		input logic bad_parity, input logic bad_stop);
		ref_t r;
		int   nbits;
		r     = ref_frame(d, cfg);
		nbits = 5 + cfg.word_len;
		drive_bit(1'b0);
		for (int i = 0; i < nbits; i++)
			drive_bit(d[i]);
		if (cfg.parity_en)
			drive_bit(r.parity ^ bad_parity);
		drive_bit(!bad_stop);
		if (cfg.two_stop)
			drive_bit(1'b1);
		// Idle gap
		drive_bit(1'b1);
	endtask

	// ******************************
	// serial_out monitor
	// ******************************
	task automatic capture_frame();
		tx_item_t             item;
		ref_t                 exp_r;
		uart_line_pkg::data_t got;
		int                   nbits;
		mon_busy = 1'b1;
		if (mon_q.size() == 0)
		begin
			other_errs++;
			$display("A frame started on serial_out with no byte expected");
		end
		else
		begin
			item  = mon_q.pop_front();
			exp_r = ref_frame(item.data, item.cfg);
			nbits = 5 + item.cfg.word_len;
			got   = '0;
			repeat (bit_clks / 2) @(negedge clk);
			check_flag("tx_start_bit", 1'b0, serial_out);
			for (int i = 0; i < nbits; i++)
			begin
				repeat (bit_clks) @(negedge clk);
				got[i] = serial_out;
			end
			check_byte("tx_data", exp_r.data, got);
			if (item.cfg.parity_en)
			begin
				repeat (bit_clks) @(negedge clk);
				check_flag("tx_parity", exp_r.parity, serial_out);
			end
			repeat (bit_clks) @(negedge clk);
			check_flag("tx_stop_bit", 1'b1, serial_out);
			if (item.cfg.two_stop)
			begin
				repeat (bit_clks) @(negedge clk);
				check_flag("tx_second_stop_bit", 1'b1, serial_out);
			end
		end
		mon_busy = 1'b0;
	endtask

	always @(negedge clk)
	begin
		if (loop_mode)
			check_flag("loopback_line_high", 1'b1, serial_out);
		if (mon_prev && !serial_out)
			capture_frame();
		mon_prev = serial_out;
	end

	// ******************************
	// Tests
	// ******************************
	task automatic test_reset_values();
		uart_line_pkg::data_t v;
		wb_read(uart_reg_pkg::REG_LC, v);
		check_byte("reset_lc", 8'h03, v);
		wb_read(uart_reg_pkg::REG_MC, v);
		check_byte("reset_mc", 8'h00, v);
		wb_read(uart_reg_pkg::REG_LS, v);
		check_byte("reset_ls", 8'h60, v);
		wb_read(uart_reg_pkg::REG_DLM, v);
		check_byte("dlm_without_dlab", 8'h00, v);
		wb_write(uart_reg_pkg::REG_LC, 8'h83);
		wb_write(uart_reg_pkg::REG_RB_TR, 8'h5a);
		wb_write(uart_reg_pkg::REG_DLM, 8'hc3);
		wb_read(uart_reg_pkg::REG_RB_TR, v);
		check_byte("dll_readback", 8'h5a, v);
		wb_read(uart_reg_pkg::REG_DLM, v);
		check_byte("dlm_readback", 8'hc3, v);
		wb_write(uart_reg_pkg::REG_LC, 8'h03);
		wb_read(uart_reg_pkg::REG_DLM, v);
		check_byte("dlm_hidden_again", 8'h00, v);
	endtask

	task automatic test_loopback_burst();
		uart_line_pkg::lc_cfg_t cfg;
		uart_line_pkg::data_t   sent[$];
		uart_line_pkg::data_t   b;
		uart_line_pkg::data_t   ls;
		ref_t                   r;
		cfg = '{2'd3, 1'b0, 1'b0, 1'b0};
		set_divisor(16'd2, cfg);
		wb_write(uart_reg_pkg::REG_MC, 8'h01 << uart_reg_pkg::MC_LOOP);
		loop_mode = 1'b1;
		for (int i = 0; i < uart_line_pkg::FIFO_DEPTH; i++)
		begin
			random_byte(b);
			sent.push_back(b);
			wb_write(uart_reg_pkg::REG_RB_TR, b);
		end
		for (int i = 0; i < uart_line_pkg::FIFO_DEPTH; i++)
		begin
			wait_ls(uart_reg_pkg::LS_DR, 1'b1, "loopback data ready", ls);
			wb_read(uart_reg_pkg::REG_RB_TR, b);
			r = ref_frame(sent.pop_front(), cfg);
			check_byte("loop_burst", r.data, b);
		end
		wait_ls(uart_reg_pkg::LS_TEMT, 1'b1, "transmitter empty", ls);
		check_flag("loop_burst_dr_clear", 1'b0, ls[uart_reg_pkg::LS_DR]);
	endtask

	task automatic test_loopback_formats();
		uart_line_pkg::lc_cfg_t cfg;
		uart_line_pkg::data_t   b;
		uart_line_pkg::data_t   got;
		uart_line_pkg::data_t   ls;
		ref_t                   r;
		for (int w = 0; w < 4; w++)
			for (int s = 0; s < 2; s++)
				for (int p = 0; p < 3; p++)
				begin
					// p is 0 for no parity, 1 for even, 2 for odd
					cfg.word_len    = 2'(w);
					cfg.two_stop    = (s != 0);
					cfg.parity_en   = (p != 0);
					cfg.even_parity = (p == 1);
					set_line(cfg);
					random_byte(b);
					r = ref_frame(b, cfg);
					wb_write(uart_reg_pkg::REG_RB_TR, b);
					wait_ls(uart_reg_pkg::LS_DR, 1'b1, "loopback data ready", ls);
					check_flag("loop_format_pe", 1'b0, ls[uart_reg_pkg::LS_PE]);
					check_flag("loop_format_fe", 1'b0, ls[uart_reg_pkg::LS_FE]);
					wb_read(uart_reg_pkg::REG_RB_TR, got);
					check_byte("loop_format", r.data, got);
					wait_ls(uart_reg_pkg::LS_TEMT, 1'b1, "transmitter empty", ls);
				end
	endtask

	task automatic test_tx_line();
		uart_line_pkg::lc_cfg_t cfgs[4];
		uart_line_pkg::data_t   b;
		uart_line_pkg::data_t   ls;
		tx_item_t               item;
		cfgs[0] = '{2'd3, 1'b0, 1'b0, 1'b0};
		cfgs[1] = '{2'd2, 1'b0, 1'b1, 1'b1};
		cfgs[2] = '{2'd0, 1'b1, 1'b1, 1'b0};
		cfgs[3] = '{2'd1, 1'b1, 1'b0, 1'b0};
		loop_mode = 1'b0;
		wb_write(uart_reg_pkg::REG_MC, 8'h00);
		for (int c = 0; c < 4; c++)
		begin
			set_line(cfgs[c]);
			for (int i = 0; i < 3; i++)
			begin
				random_byte(b);
				item.cfg  = cfgs[c];
				item.data = b;
				mon_q.push_back(item);
				wb_write(uart_reg_pkg::REG_RB_TR, b);
			end
			wait_monitor_idle();
			wait_ls(uart_reg_pkg::LS_TEMT, 1'b1, "transmitter empty", ls);
		end
	endtask

	task automatic test_rx_errors();
		uart_line_pkg::lc_cfg_t cfg;
		uart_line_pkg::data_t   b;
		uart_line_pkg::data_t   got;
		uart_line_pkg::data_t   ls;
		ref_t                   r;
		cfg = '{2'd3, 1'b0, 1'b1, 1'b1};
		set_line(cfg);
		random_byte(b);
		r = ref_frame(b, cfg);
		send_frame(b, cfg, 1'b1, 1'b0);
		wait_ls(uart_reg_pkg::LS_DR, 1'b1, "received data", ls);
		check_flag("rx_bad_parity_pe", 1'b1, ls[uart_reg_pkg::LS_PE]);
		check_flag("rx_bad_parity_fe", 1'b0, ls[uart_reg_pkg::LS_FE]);
		wb_read(uart_reg_pkg::REG_RB_TR, got);
		check_byte("rx_bad_parity_data", r.data, got);
		random_byte(b);
		r = ref_frame(b, cfg);
		send_frame(b, cfg, 1'b0, 1'b1);
		wait_ls(uart_reg_pkg::LS_DR, 1'b1, "received data", ls);
		check_flag("rx_low_stop_fe", 1'b1, ls[uart_reg_pkg::LS_FE]);
		check_flag("rx_low_stop_pe", 1'b0, ls[uart_reg_pkg::LS_PE]);
		wb_read(uart_reg_pkg::REG_RB_TR, got);
		check_byte("rx_low_stop_data", r.data, got);
		wb_read(uart_reg_pkg::REG_LS, ls);
		check_flag("rx_pe_cleared", 1'b0, ls[uart_reg_pkg::LS_PE]);
		check_flag("rx_fe_cleared", 1'b0, ls[uart_reg_pkg::LS_FE]);
	endtask

	task automatic test_rx_overrun();
		uart_line_pkg::lc_cfg_t cfg;
		uart_line_pkg::data_t   sent[$];
		uart_line_pkg::data_t   b;
		uart_line_pkg::data_t   ls;
		ref_t                   r;
		cfg = '{2'd3, 1'b0, 1'b0, 1'b0};
		set_line(cfg);
		for (int i = 0; i <= uart_line_pkg::FIFO_DEPTH; i++)
		begin
			random_byte(b);
			sent.push_back(b);
			send_frame(b, cfg, 1'b0, 1'b0);
		end
		wb_read(uart_reg_pkg::REG_LS, ls);
		check_flag("overrun_oe", 1'b1, ls[uart_reg_pkg::LS_OE]);
		check_flag("overrun_dr", 1'b1, ls[uart_reg_pkg::LS_DR]);
		for (int i = 0; i < uart_line_pkg::FIFO_DEPTH; i++)
		begin
			wb_read(uart_reg_pkg::REG_RB_TR, b);
			r = ref_frame(sent.pop_front(), cfg);
			check_byte("overrun_data", r.data, b);
		end
		wb_read(uart_reg_pkg::REG_LS, ls);
		check_flag("overrun_dr_clear", 1'b0, ls[uart_reg_pkg::LS_DR]);
	endtask

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b1;
		wb_req     = '0;
		serial_in  = 1'b1;
		lfsr       = 32'h68e2;
		value_errs = 0;
		other_errs = 0;
		bit_clks   = 0;
		loop_mode  = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_reset_values();
		test_loopback_burst();
		test_loopback_formats();
		test_tx_line();
		test_rx_errors();
		test_rx_overrun();
		end_run();
	end

endmodule

// File: list.f
uart_line_pkg.sv
uart_reg_pkg.sv
uart_fifo.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_bus_regs.sv
uart_core.sv
tb_uart.sv

// File: Makefile
# Verilator build of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Output is kept in a shell variable and searched for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
